// File: spi_master.f
+incdir+verification
src/spi_master_pkg.sv
src/spi_byte_fifo.sv
src/spi_baud_gen.sv
src/spi_regs.sv
src/spi_frame_engine.sv
src/spi_master_top.sv
verification/tb_spi_master.sv

// File: verification/tb_spi_tasks.svh
task automatic report_mismatch(input string msg);
    mismatch_cnt++;
    $display("MISMATCH at time %0t: %s", $time, msg);
endtask

task automatic count_failure(input string msg);
    fail_cnt++;
    $display("ERROR: %s", msg);
endtask

// ci [18], cp [17], pol [16], pm [15:12], then before, after and gap delays
function automatic logic [31:0] csmode_word(input logic ci, input logic cp,
                                            input logic [3:0] pm, input logic [3:0] dly);
    return {13'h0, ci, cp, 1'b0, pm, dly, dly, dly};
endfunction

function automatic logic [31:0] spcom_word(input logic [1:0] cs, input logic [7:0] len);
    return {22'h0, cs, len};
endfunction

task automatic idle_cycles(input int n);
    repeat (n) @(posedge S_SYSCLK);
    #2;
endtask

task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    reg_wr.wen  = 1'b1;
    reg_wr.addr = addr;
    reg_wr.data = data;
    @(posedge S_SYSCLK);
    #2;
    reg_wr.wen = 1'b0;
endtask

task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
    araddr   = addr;
    reg_rden = 1'b1;
    #1;
    data = rdata;
    @(posedge S_SYSCLK);
    #2;
    reg_rden = 1'b0;
endtask

task automatic wait_done();
    logic [31:0] v;
    int          polls;
    v     = '0;
    polls = 0;
    while (!v[SPIE_DON] && polls < 2000) begin
        reg_read(ADDR_SPIE, v);
        polls++;
    end
    if (!v[SPIE_DON]) count_failure("frame did not finish, DON never set");
endtask

task automatic clear_done();
    reg_write(ADDR_SPIE, 32'h1 << SPIE_DON);
endtask

task automatic expect_rx(input logic [7:0] exp, input string tag);
    logic [31:0] v;
    reg_read(ADDR_SPIRF, v);
    if (v[7:0] !== exp)
        report_mismatch($sformatf("%s: SPIRF read %02h, expected %02h", tag, v[7:0], exp));
endtask

task automatic check_reset_state();
    logic [31:0] v;
    if (spi_sel !== 4'hF) report_mismatch($sformatf("select lines after reset %b", spi_sel));
    if (irq !== 1'b0) report_mismatch("irq high after reset");
    if (spi_sck !== 1'b1 || spi_mosi !== 1'b0) report_mismatch("sck or mosi wrong after reset");
    reg_read(ADDR_SPIE, v);
    if (v[SPIE_TXE] !== 1'b1 || v[SPIE_TNF] !== 1'b1 || v[SPIE_RNE] !== 1'b0)
        report_mismatch($sformatf("SPIE after reset reads %h", v));
endtask

task automatic loopback_frame();
    logic [7:0]  pay [4];
    logic [31:0] v;
    reg_write(ADDR_SPMODE, MODE_EN | MODE_LOOP);
    for (int i = 0; i < 4; i++) begin
        pay[i] = 8'($random(seed));
        reg_write(ADDR_SPITF, {24'h0, pay[i]});
    end
    reg_write(ADDR_SPCOM, spcom_word(2'd0, 8'd3));
    wait_done();
    clear_done();
    for (int i = 0; i < 4; i++) expect_rx(pay[i], "loopback");
    idle_cycles(2); // SPIE level bits trail the fifo flags
    reg_read(ADDR_SPIE, v);
    if (v[SPIE_RNE] !== 1'b0) report_mismatch("RNE still set after draining SPIRF");
endtask

task automatic external_frame(input logic ci, input logic cp);
    logic [7:0] pay [3];
    reg_write(ADDR_SPMODE, MODE_EN);
    reg_write(ADDR_CSMODE0 + 8'h04, csmode_word(ci, cp, 4'd1, 4'd1));
    slave_ci = ci;
    slave_cp = cp;
    miso_idx = 0;
    mosi_rec.delete();
    for (int i = 0; i < 3; i++) begin
        pay[i] = 8'($random(seed));
        reg_write(ADDR_SPITF, {24'h0, pay[i]});
    end
    reg_write(ADDR_SPCOM, spcom_word(2'd1, 8'd2));
    idle_cycles(3);
    if (spi_sel !== 4'b1101) report_mismatch($sformatf("select lines in cs1 frame %b", spi_sel));
    wait_done();
    clear_done();
    if (spi_sck !== ci) report_mismatch($sformatf("sck rests at %b, ci is %b", spi_sck, ci));
    if (mosi_rec.size() != 3) begin
        report_mismatch($sformatf("slave saw %0d bytes on mosi, expected 3", mosi_rec.size()));
    end else begin
        for (int i = 0; i < 3; i++)
            if (mosi_rec[i] !== pay[i])
                report_mismatch($sformatf("mosi byte %0d is %02h, expected %02h",
                                          i, mosi_rec[i], pay[i]));
    end
    for (int i = 0; i < 3; i++) expect_rx(miso_pat[i], "external");
endtask

task automatic tx_stall();
    logic [7:0]  pay [3];
    logic [31:0] v;
    for (int i = 0; i < 3; i++) pay[i] = 8'($random(seed));
    reg_write(ADDR_SPMODE, MODE_EN | MODE_LOOP);
    reg_write(ADDR_SPITF, {24'h0, pay[0]});
    reg_write(ADDR_SPCOM, spcom_word(2'd0, 8'd2));
    idle_cycles(80); // first byte gone, engine parked in data-wait
    reg_read(ADDR_SPIE, v);
    if (spi_sel[0] !== 1'b0) report_mismatch("select released while waiting for tx data");
    if (v[SPIE_DON] !== 1'b0) report_mismatch("DON set before the stalled frame finished");
    reg_write(ADDR_SPITF, {24'h0, pay[1]});
    reg_write(ADDR_SPITF, {24'h0, pay[2]});
    wait_done();
    clear_done();
    for (int i = 0; i < 3; i++) expect_rx(pay[i], "stall");
endtask

task automatic done_interrupt();
    logic [7:0] b;
    b = 8'($random(seed));
    reg_write(ADDR_SPIM, 32'h1 << SPIE_DON);
    if (irq !== 1'b0) report_mismatch("irq high while DON is clear");
    reg_write(ADDR_SPITF, {24'h0, b});
    reg_write(ADDR_SPCOM, spcom_word(2'd0, 8'd0));
    wait_done();
    if (irq !== 1'b1) report_mismatch("irq did not rise after the frame ended");
    clear_done();
    if (irq !== 1'b0) report_mismatch("irq still high after DON was cleared");
    expect_rx(b, "irq frame");
endtask

// File: verification/tb_spi_master.sv
`timescale 1ns/10ps
module tb_spi_master;
    import spi_master_pkg::*;

    // longest test is a few hundred clocks, polling included
    localparam int MAX_CYCLES = 40000;
    localparam logic [31:0] MODE_EN   = 32'h8000_0000;
    localparam logic [31:0] MODE_LOOP = 32'h4000_0000;

    logic              S_SYSCLK;
    logic              S_RESETN;
    reg_wr_t           reg_wr;
    logic              reg_rden;
    logic [ADDR_W-1:0] araddr;
    logic              spi_miso;
    logic [DATA_W-1:0] rdata;
    logic              irq;
    logic              spi_sck;
    logic              spi_mosi;
    logic [NCS-1:0]    spi_sel;

    int                mismatch_cnt;
    int                fail_cnt;
    int                cycles;
    integer            seed;

    // slave model state
    logic [7:0]        miso_pat [8];
    logic [7:0]        mosi_rec [$];
    int                miso_idx;
    logic              slave_ci;
    logic              slave_cp;
    logic              sck_prev;
    logic              sel_seen;
    logic              lead;
    logic [7:0]        s_tx;
    logic [7:0]        s_rx;
    int                s_bit;
    int                s_rbit;

    spi_master_top DUT (
        .S_SYSCLK(S_SYSCLK), .S_RESETN(S_RESETN),
        .i_reg_wr(reg_wr), .i_reg_rden(reg_rden), .i_araddr(araddr),
        .i_spi_miso(spi_miso),
        .o_rdata(rdata), .o_irq(irq), .o_spi_sck(spi_sck),
        .o_spi_mosi(spi_mosi), .o_spi_sel(spi_sel)
    );

    `include "tb_spi_tasks.svh"

    task load_slave_byte();
        s_tx     = miso_pat[miso_idx % 8];
        miso_idx = miso_idx + 1;
    endtask

    initial begin
        S_SYSCLK = 1'b0;
        forever #20 S_SYSCLK = ~S_SYSCLK;
    end

    // slave on CS0/CS1, looks at the bus 2 ns after each rising edge
    initial begin
        miso_pat = '{8'hA5, 8'h3C, 8'hE1, 8'h5A, 8'h0F, 8'hC3, 8'h96, 8'h7E};
        spi_miso = 1'b0;
        slave_ci = 1'b1;
        slave_cp = 1'b0;
        sck_prev = 1'b1;
        sel_seen = 1'b0;
        s_tx     = '0;
        s_rx     = '0;
        s_bit    = 0;
        s_rbit   = 0;
        miso_idx = 0;
        forever begin
            @(posedge S_SYSCLK);
            #2;
            if (spi_sel[0] && spi_sel[1]) begin
                sel_seen = 1'b0;
                s_bit    = 0;
                s_rbit   = 0;
            end else if (!sel_seen) begin
                sel_seen = 1'b1;
                if (!slave_cp) begin
                    load_slave_byte(); // msb out before the first edge
                    spi_miso = s_tx[7];
                end
            end else if (spi_sck != sck_prev) begin
                lead = (spi_sck != slave_ci);
                if (lead != slave_cp) begin
                    s_rx   = {s_rx[6:0], spi_mosi};
                    s_rbit = s_rbit + 1;
                    if (s_rbit == 8) begin
                        mosi_rec.push_back(s_rx);
                        s_rbit = 0;
                    end
                end else begin
                    if (!slave_cp) s_bit = (s_bit + 1) % 8;
                    if (s_bit == 0) load_slave_byte();
                    spi_miso = s_tx[7 - s_bit];
                    if (slave_cp) s_bit = (s_bit + 1) % 8;
                end
            end
            sck_prev = spi_sck;
        end
    end

    initial begin
        reg_wr       = '0;
        reg_rden     = 1'b0;
        araddr       = '0;
        S_RESETN     = 1'b0;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        seed         = 32'h811d_1e52;
        repeat (8) @(posedge S_SYSCLK);
        #2;
        S_RESETN = 1'b1;
        idle_cycles(1);
        check_reset_state();
        loopback_frame();
        external_frame(1'b0, 1'b0);
        external_frame(1'b1, 1'b1);
        tx_stall();
        done_interrupt();
        idle_cycles(4);
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge S_SYSCLK);
            cycles = cycles + 1;
        end
        $display("run stopped after %0d cycles without finishing the tests", MAX_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: src/spi_master_top.sv
`timescale 1ns/10ps
module spi_master_top (
    input  logic                              S_SYSCLK,
    input  logic                              S_RESETN,
    input  spi_master_pkg::reg_wr_t           i_reg_wr,
    input  logic                              i_reg_rden,
    input  logic [spi_master_pkg::ADDR_W-1:0] i_araddr,
    input  logic                              i_spi_miso,
    output logic [spi_master_pkg::DATA_W-1:0] o_rdata,
    output logic                              o_irq,
    output logic                              o_spi_sck,
    output logic                              o_spi_mosi,
    output logic [spi_master_pkg::NCS-1:0]    o_spi_sel
);
    import spi_master_pkg::*;

    spcom_t          spcom;
    csmode_t         csmode;
    engine_status_t  eng;
    logic            start;
    logic            loop;
    logic            fifo_clr;
    logic [NCS-1:0]  cs_idle_pol;
    logic            tx_push, tx_pop, tx_full, tx_empty;
    logic            rx_push, rx_pop, rx_full, rx_empty;
    logic [7:0]      tx_wdata, tx_data, rx_wdata, rx_data;
    logic            brg_run, brg_sck, brg_lead, brg_trail;
    logic [PM_W-1:0] brg_pm;

    spi_regs u_regs (
        .S_SYSCLK(S_SYSCLK), .S_RESETN(S_RESETN),
        .i_reg_wr(i_reg_wr), .i_reg_rden(i_reg_rden), .i_araddr(i_araddr),
        .i_eng(eng),
        .i_tx_full(tx_full), .i_tx_empty(tx_empty),
        .i_rx_empty(rx_empty), .i_rx_full(rx_full), .i_rx_data(rx_data),
        .o_rdata(o_rdata), .o_irq(o_irq), .o_start(start),
        .o_spcom(spcom), .o_csmode(csmode), .o_loop(loop),
        .o_tx_push(tx_push), .o_tx_wdata(tx_wdata), .o_rx_pop(rx_pop),
        .o_fifo_clr(fifo_clr), .o_cs_idle_pol(cs_idle_pol)
    );

    spi_byte_fifo #(.DEPTH(FIFO_DEPTH)) u_txfifo (
        .S_SYSCLK(S_SYSCLK), .S_RESETN(S_RESETN), .i_clr(fifo_clr),
        .i_push(tx_push), .i_data(tx_wdata), .i_pop(tx_pop),
        .o_data(tx_data), .o_full(tx_full), .o_empty(tx_empty)
    );

    // received bytes dropped by the fifo when full
    spi_byte_fifo #(.DEPTH(FIFO_DEPTH)) u_rxfifo (
        .S_SYSCLK(S_SYSCLK), .S_RESETN(S_RESETN), .i_clr(fifo_clr),
        .i_push(rx_push), .i_data(rx_wdata), .i_pop(rx_pop),
        .o_data(rx_data), .o_full(rx_full), .o_empty(rx_empty)
    );

    spi_baud_gen u_brg (
        .S_SYSCLK(S_SYSCLK), .S_RESETN(S_RESETN),
        .i_run(brg_run), .i_pm(brg_pm),
        .o_sck(brg_sck), .o_lead(brg_lead), .o_trail(brg_trail)
    );

    spi_frame_engine u_engine (
        .S_SYSCLK(S_SYSCLK), .S_RESETN(S_RESETN),
        .i_start(start), .i_spcom(spcom), .i_csmode(csmode),
        .i_cs_idle_pol(cs_idle_pol), .i_loop(loop),
        .i_tx_data(tx_data), .i_tx_empty(tx_empty),
        .i_lead(brg_lead), .i_trail(brg_trail), .i_sck(brg_sck),
        .i_spi_miso(i_spi_miso),
        .o_status(eng), .o_tx_pop(tx_pop),
        .o_rx_push(rx_push), .o_rx_data(rx_wdata),
        .o_brg_run(brg_run), .o_brg_pm(brg_pm),
        .o_spi_sck(o_spi_sck), .o_spi_mosi(o_spi_mosi), .o_spi_sel(o_spi_sel)
    );

endmodule

// File: src/spi_frame_engine.sv
`timescale 1ns/10ps
module spi_frame_engine (
    input  logic                              S_SYSCLK,
    input  logic                              S_RESETN,
    input  logic                              i_start,
    input  spi_master_pkg::spcom_t            i_spcom,
    input  spi_master_pkg::csmode_t           i_csmode,
    input  logic [spi_master_pkg::NCS-1:0]    i_cs_idle_pol,
    input  logic                              i_loop,
    input  logic [7:0]                        i_tx_data,
    input  logic                              i_tx_empty,
    input  logic                              i_lead,
    input  logic                              i_trail,
    input  logic                              i_sck,
    input  logic                              i_spi_miso,
    output spi_master_pkg::engine_status_t    o_status,
    output logic                              o_tx_pop,
    output logic                              o_rx_push,
    output logic [7:0]                        o_rx_data,
    output logic                              o_brg_run,
    output logic [spi_master_pkg::PM_W-1:0]   o_brg_pm,
    output logic                              o_spi_sck,
    output logic                              o_spi_mosi,
    output logic [spi_master_pkg::NCS-1:0]    o_spi_sel
);
    import spi_master_pkg::*;

    frame_state_e         state;
    logic [DLY_W-1:0]     dly_cnt;
    logic [TRANLEN_W-1:0] chr_cnt;
    logic [2:0]           bit_cnt;
    logic [7:0]           tx_sh;
    logic [7:0]           rx_sh;
    logic                 pend_start, sel_act, done_q, rx_push_q, dout;
    logic                 din, shift_edge, sample_edge, char_end, last_char, load;
    logic                 in_trans;

    assign in_trans    = (state == FS_IN_TRANS);
    assign din         = i_loop ? dout : i_spi_miso;
    assign shift_edge  = in_trans && (i_csmode.cp ? i_lead : i_trail);
    assign sample_edge = in_trans && (i_csmode.cp ? i_trail : i_lead);
    assign char_end    = in_trans && i_trail && (bit_cnt == 3'd7);
    assign last_char   = (chr_cnt == i_spcom.tranlen);

    // next character taken from the tx fifo
    always_comb begin
        case (state)
            FS_BEF_WAIT:  load = i_trail && (dly_cnt == '0) && !i_tx_empty;
            FS_DATA_WAIT: load = !i_tx_empty;
            FS_IN_TRANS:  load = char_end && !last_char && !i_tx_empty;
            default:      load = 1'b0;
        endcase
    end

    always_ff @(posedge S_SYSCLK) begin
        if (!S_RESETN) begin
            state      <= FS_IDLE;
            dly_cnt    <= '0;
            chr_cnt    <= '0;
            pend_start <= 1'b0;
            sel_act    <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                FS_IDLE: if (i_start) begin
                    state   <= FS_BEF_WAIT;
                    sel_act <= 1'b1;
                    dly_cnt <= i_csmode.csbef;
                    chr_cnt <= '0;
                end
                FS_BEF_WAIT: if (i_trail) begin
                    if (dly_cnt != '0) dly_cnt <= dly_cnt - 1'b1;
                    else               state   <= load ? FS_IN_TRANS : FS_DATA_WAIT;
                end
                FS_DATA_WAIT: if (load) state <= FS_IN_TRANS;
                FS_IN_TRANS: if (char_end) begin
                    if (last_char) begin
                        state   <= FS_AFT_WAIT;
                        dly_cnt <= i_csmode.csaft;
                    end else begin
                        chr_cnt <= chr_cnt + 1'b1;
                        if (!load) state <= FS_DATA_WAIT; // tx ran dry, sel held
                    end
                end
                FS_AFT_WAIT: if (i_trail) begin
                    if (dly_cnt != '0) begin
                        dly_cnt <= dly_cnt - 1'b1;
                    end else begin
                        state   <= FS_CG_WAIT;
                        dly_cnt <= i_csmode.cscg;
                        sel_act <= 1'b0;
                        done_q  <= 1'b1;
                    end
                end
                FS_CG_WAIT: begin
                    if (i_start) pend_start <= 1'b1;
                    if (i_trail && dly_cnt != '0) begin
                        dly_cnt <= dly_cnt - 1'b1;
                    end else if (i_trail) begin
                        if (pend_start || i_start) begin
                            state      <= FS_BEF_WAIT;
                            sel_act    <= 1'b1;
                            dly_cnt    <= i_csmode.csbef;
                            chr_cnt    <= '0;
                            pend_start <= 1'b0;
                        end else begin
                            state <= FS_IDLE;
                        end
                    end
                end
                default: state <= FS_IDLE;
            endcase
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (!S_RESETN) begin
            bit_cnt   <= '0;
            dout      <= 1'b0;
            rx_push_q <= 1'b0;
        end else begin
            rx_push_q <= char_end;
            if (load) begin
                bit_cnt <= '0;
                if (!i_csmode.cp) dout <= i_tx_data[7]; // cp=0 presents msb early
            end else begin
                if (in_trans && i_trail) bit_cnt <= bit_cnt + 1'b1;
                if (shift_edge)          dout    <= tx_sh[7];
            end
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (load) begin
            tx_sh <= i_csmode.cp ? i_tx_data : {i_tx_data[6:0], 1'b0};
        end else if (shift_edge) begin
            tx_sh <= {tx_sh[6:0], 1'b0};
        end
        if (sample_edge) begin
            rx_sh <= {rx_sh[6:0], din};
        end
    end

    always_comb begin
        for (int i = 0; i < NCS; i++) begin
            if (sel_act && (i_spcom.cs == CS_W'(i))) o_spi_sel[i] = ~i_cs_idle_pol[i];
            else                                     o_spi_sel[i] = i_cs_idle_pol[i];
        end
    end

    assign o_status.busy      = (state != FS_IDLE);
    assign o_status.can_start = (state == FS_IDLE) || (state == FS_CG_WAIT);
    assign o_status.done      = done_q;
    assign o_tx_pop   = load;
    assign o_rx_push  = rx_push_q;
    assign o_rx_data  = rx_sh;
    assign o_brg_run  = (state != FS_IDLE) && (state != FS_DATA_WAIT);
    assign o_brg_pm   = i_csmode.pm;
    assign o_spi_sck  = in_trans ? (i_sck ^ i_csmode.ci) : i_csmode.ci;
    assign o_spi_mosi = dout;

endmodule

// File: src/spi_regs.sv
`timescale 1ns/10ps
module spi_regs (
    input  logic                              S_SYSCLK,
    input  logic                              S_RESETN,
    input  spi_master_pkg::reg_wr_t           i_reg_wr,
    input  logic                              i_reg_rden,
    input  logic [spi_master_pkg::ADDR_W-1:0] i_araddr,
    input  spi_master_pkg::engine_status_t    i_eng,
    input  logic                              i_tx_full,
    input  logic                              i_tx_empty,
    input  logic                              i_rx_empty,
    input  logic                              i_rx_full,
    input  logic [7:0]                        i_rx_data,
    output logic [spi_master_pkg::DATA_W-1:0] o_rdata,
    output logic                              o_irq,
    output logic                              o_start,
    output spi_master_pkg::spcom_t            o_spcom,
    output spi_master_pkg::csmode_t           o_csmode,
    output logic                              o_loop,
    output logic                              o_tx_push,
    output logic [7:0]                        o_tx_wdata,
    output logic                              o_rx_pop,
    output logic                              o_fifo_clr,
    output logic [spi_master_pkg::NCS-1:0]    o_cs_idle_pol
);
    import spi_master_pkg::*;

    logic              spm_en;
    logic              spm_loop;
    logic [SPIE_W-1:0] spie;
    logic [SPIE_W-1:0] spim;
    spcom_t            spcom;
    csmode_t           csmode_r [NCS];
    logic              start_q;
    logic              wr_spmode, wr_spie, wr_spim, wr_spcom, wr_spitf, wr_cs;
    logic              rd_cs;
    logic [CS_W-1:0]   cs_wr_idx;
    logic [CS_W-1:0]   cs_rd_idx;

    assign wr_spmode = i_reg_wr.wen && (i_reg_wr.addr == ADDR_SPMODE);
    assign wr_spie   = i_reg_wr.wen && (i_reg_wr.addr == ADDR_SPIE);
    assign wr_spim   = i_reg_wr.wen && (i_reg_wr.addr == ADDR_SPIM);
    assign wr_spcom  = i_reg_wr.wen && (i_reg_wr.addr == ADDR_SPCOM);
    assign wr_spitf  = i_reg_wr.wen && (i_reg_wr.addr == ADDR_SPITF);

    // CSMODE block decodes on the upper address bits
    assign wr_cs     = i_reg_wr.wen &&
                       (i_reg_wr.addr[ADDR_W-1:CS_W+2] == ADDR_CSMODE0[ADDR_W-1:CS_W+2]);
    assign cs_wr_idx = i_reg_wr.addr[CS_W+1:2];
    assign rd_cs     = (i_araddr[ADDR_W-1:CS_W+2] == ADDR_CSMODE0[ADDR_W-1:CS_W+2]);
    assign cs_rd_idx = i_araddr[CS_W+1:2];

    always_ff @(posedge S_SYSCLK) begin
        if (!S_RESETN) begin
            spm_en   <= 1'b0;
            spm_loop <= 1'b0;
            spie     <= SPIE_DEF;
            spim     <= '0;
            spcom    <= '0;
            start_q  <= 1'b0;
            for (int i = 0; i < NCS; i++) begin
                csmode_r[i] <= CSMODE_DEF;
            end
        end else begin
            start_q <= 1'b0;

            // level bits follow the fifo flags
            spie[SPIE_TNF] <= !i_tx_full;
            spie[SPIE_TXE] <= i_tx_empty;
            spie[SPIE_RNE] <= !i_rx_empty;
            spie[SPIE_RXF] <= i_rx_full;
            if (i_eng.done) begin
                spie[SPIE_DON] <= 1'b1;
            end else if (wr_spie && i_reg_wr.data[SPIE_DON]) begin
                spie[SPIE_DON] <= 1'b0; // w1c
            end

            if (wr_spmode) begin
                spm_en   <= i_reg_wr.data[SPMODE_EN];
                spm_loop <= i_reg_wr.data[SPMODE_LOOP];
            end
            if (wr_spim) begin
                spim <= i_reg_wr.data[SPIE_W-1:0];
            end
            if (wr_spcom && spm_en && i_eng.can_start) begin
                spcom   <= spcom_t'(i_reg_wr.data[SPCOM_W-1:0]);
                start_q <= 1'b1;
            end
            if (wr_cs) begin
                csmode_r[cs_wr_idx] <= csmode_t'(i_reg_wr.data[CSMODE_W-1:0]);
            end
        end
    end

    always_comb begin
        o_rdata = '0;
        if (rd_cs) begin
            o_rdata[CSMODE_W-1:0] = csmode_r[cs_rd_idx];
        end else begin
            case (i_araddr)
                ADDR_SPMODE: begin
                    o_rdata[SPMODE_EN]   = spm_en;
                    o_rdata[SPMODE_LOOP] = spm_loop;
                end
                ADDR_SPIE:  o_rdata[SPIE_W-1:0]  = spie;
                ADDR_SPIM:  o_rdata[SPIE_W-1:0]  = spim;
                ADDR_SPCOM: o_rdata[SPCOM_W-1:0] = spcom;
                ADDR_SPIRF: o_rdata[7:0] = i_rx_empty ? 8'h00 : i_rx_data;
                default: ;  // SPITF is write only
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < NCS; i++) begin
            o_cs_idle_pol[i] = ~csmode_r[i].pol;
        end
    end

    assign o_rx_pop   = i_reg_rden && (i_araddr == ADDR_SPIRF) && !i_rx_empty;
    assign o_tx_push  = wr_spitf && spm_en && !i_tx_full;
    assign o_tx_wdata = i_reg_wr.data[7:0];
    assign o_fifo_clr = !spm_en;
    assign o_irq      = |(spie & spim);
    assign o_start    = start_q;
    assign o_spcom    = spcom;
    assign o_csmode   = csmode_r[spcom.cs];
    assign o_loop     = spm_loop;

endmodule

// File: src/spi_baud_gen.sv
`timescale 1ns/10ps
module spi_baud_gen (
    input  logic                            S_SYSCLK,
    input  logic                            S_RESETN,
    input  logic                            i_run,
    input  logic [spi_master_pkg::PM_W-1:0] i_pm,
    output logic                            o_sck,
    output logic                            o_lead,
    output logic                            o_trail
);
    import spi_master_pkg::*;

    logic [PM_W-1:0] cnt;
    logic            phase;    // 1 while away from idle level
    logic            half_end;

    assign half_end = i_run && (cnt == i_pm);

    always_ff @(posedge S_SYSCLK) begin
        if (!S_RESETN) begin
            cnt   <= '0;
            phase <= 1'b0;
        end else if (!i_run) begin
            // parked in idle phase, next run starts clean
            cnt   <= '0;
            phase <= 1'b0;
        end else if (half_end) begin
            cnt   <= '0;
            phase <= ~phase;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign o_sck   = phase;
    assign o_lead  = half_end && !phase;
    assign o_trail = half_end && phase;

endmodule

// File: src/spi_byte_fifo.sv
`timescale 1ns/10ps
module spi_byte_fifo #(
    parameter int DEPTH = 16
) (
    input  logic       S_SYSCLK,
    input  logic       S_RESETN,
    input  logic       i_clr,
    input  logic       i_push,
    input  logic [7:0] i_data,
    input  logic       i_pop,
    output logic [7:0] o_data,
    output logic       o_full,
    output logic       o_empty
);
    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge S_SYSCLK) begin
        if (!S_RESETN || i_clr) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    assign o_data  = mem[rd_ptr]; // head, no read latency
    assign o_full  = (count == CW'(DEPTH));
    assign o_empty = (count == '0);

endmodule

// File: src/spi_master_pkg.sv
package spi_master_pkg;

    localparam int NCS        = 4;
    localparam int CS_W       = 2;
    localparam int FIFO_DEPTH = 16;
    localparam int PM_W       = 4;
    localparam int DLY_W      = 4;
    localparam int TRANLEN_W  = 8;
    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 8;

    // register map, byte addresses
    localparam logic [ADDR_W-1:0] ADDR_SPMODE  = 8'h00;
    localparam logic [ADDR_W-1:0] ADDR_SPIE    = 8'h04;
    localparam logic [ADDR_W-1:0] ADDR_SPIM    = 8'h08;
    localparam logic [ADDR_W-1:0] ADDR_SPCOM   = 8'h0C;
    localparam logic [ADDR_W-1:0] ADDR_SPITF   = 8'h10;
    localparam logic [ADDR_W-1:0] ADDR_SPIRF   = 8'h14;
    localparam logic [ADDR_W-1:0] ADDR_CSMODE0 = 8'h20; // CSMODE1..3 every 4 bytes

    localparam int SPMODE_EN   = 31;
    localparam int SPMODE_LOOP = 30;

    localparam int SPIE_DON = 0;
    localparam int SPIE_TNF = 1;
    localparam int SPIE_TXE = 2;
    localparam int SPIE_RNE = 3;
    localparam int SPIE_RXF = 4;
    localparam int SPIE_W   = 5;
    localparam logic [SPIE_W-1:0] SPIE_DEF = 5'b00110; // tx empty, tx not full

    typedef struct packed {
        logic             ci;    // sck idle level
        logic             cp;    // sample on trailing edge
        logic             pol;   // select active high
        logic [PM_W-1:0]  pm;
        logic [DLY_W-1:0] csbef;
        logic [DLY_W-1:0] csaft;
        logic [DLY_W-1:0] cscg;
    } csmode_t;

    localparam int CSMODE_W = $bits(csmode_t);
    // select active low, sck idles high
    localparam csmode_t CSMODE_DEF = '{ci: 1'b1, default: '0};

    typedef struct packed {
        logic [CS_W-1:0]      cs;
        logic [TRANLEN_W-1:0] tranlen; // characters minus one
    } spcom_t;

    localparam int SPCOM_W = $bits(spcom_t);

    typedef struct packed {
        logic              wen;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } reg_wr_t;

    typedef enum logic [2:0] {
        FS_IDLE,
        FS_BEF_WAIT,
        FS_DATA_WAIT,
        FS_IN_TRANS,
        FS_AFT_WAIT,
        FS_CG_WAIT
    } frame_state_e;

    typedef struct packed {
        logic busy;
        logic can_start;
        logic done;      // one cycle at end of frame
    } engine_status_t;

endpackage
